// ==== hw/hist_bin_ram.sv ====
`timescale 1ns/100ps
`include "hist_settings.svh"

module hist_bin_ram (
    input  logic                 clk,
    input  logic                 res,
    input  hist_pkg::bin_addr_t  addr,
    hist_ctrl_if.ram             ctrl,
    output logic                 bin_valid,
    output hist_pkg::bin_count_t bin_counts,
    output logic                 data_finish,
    output logic                 his_num
);

    import hist_pkg::*;

    bin_count_t mem [`HIST_BINS];

    bin_addr_t  rd_addr;
    bin_count_t rd_q;
    bin_addr_t  addr_q;
    logic       hit_q;
    bin_count_t inc_val;
    logic       fwd;
    logic       vld_d1;
    logic       last_d1;
    logic       last_d2;

    // ##################################################
    // Read stage
    // ##################################################

    // Readout sweeps the memory, otherwise the event address is read
    assign rd_addr = (ctrl.state == ST_READOUT) ? ctrl.sweep_addr : addr;

    // Same bin written this cycle, take the new value
    assign fwd = hit_q && (addr_q == rd_addr);

    always_ff @(posedge clk) begin
        rd_q   <= fwd ? inc_val : mem[rd_addr];
        addr_q <= addr;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= ctrl.hit;
        end
    end

    // ##################################################
    // Write stage
    // ##################################################

    // Saturating increment
    assign inc_val = (rd_q == '1) ? rd_q : rd_q + 1'b1;

    always_ff @(posedge clk) begin
        if (ctrl.state == ST_CLEAR) begin
            mem[ctrl.sweep_addr] <= '0;
        end else if (hit_q) begin
            mem[addr_q] <= inc_val;
        end
    end

    // ##################################################
    // Readout
    // ##################################################

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            vld_d1      <= 1'b0;
            last_d1     <= 1'b0;
            last_d2     <= 1'b0;
            bin_valid   <= 1'b0;
            bin_counts  <= '0;
            data_finish <= 1'b0;
            his_num     <= 1'b0;
        end else begin
            vld_d1      <= (ctrl.state == ST_READOUT);
            last_d1     <= (ctrl.state == ST_READOUT) && (ctrl.sweep_addr == bin_addr_t'('1));
            // Output register, two cycles behind the sweep
            bin_valid   <= vld_d1;
            last_d2     <= last_d1;
            if (vld_d1) begin
                bin_counts <= rd_q;
            end
            data_finish <= last_d2;
            his_num     <= his_num ^ last_d2;   // one flip per finished histogram
        end
    end

endmodule

// ==== hw/hist_builder_top.sv ====
`timescale 1ns/100ps

module hist_builder_top (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 wr_en,
    input  hist_pkg::bin_addr_t  addr,
    output logic                 ready,
    output logic                 bin_valid,
    output logic                 data_finish,
    output logic                 his_num,
    output hist_pkg::bin_count_t bin_counts
);

    // Control bundle shared by the three blocks
    hist_ctrl_if ctrl ();

    // ##################################################
    // Sequencer
    // ##################################################

    hist_fsm i_fsm (
        .clk   (clk),
        .res   (res),
        .wr_en (wr_en),
        .ready (ready),
        .ctrl  (ctrl.fsm)
    );

    // ##################################################
    // Acquisition counters and sweep timer
    // ##################################################

    hist_counters i_counters (
        .clk  (clk),
        .res  (res),
        .ctrl (ctrl.cnt)
    );

    // ##################################################
    // Bin memory and readout
    // ##################################################

    hist_bin_ram i_bin_ram (
        .clk         (clk),
        .res         (res),
        .addr        (addr),
        .ctrl        (ctrl.ram),
        .bin_valid   (bin_valid),
        .bin_counts  (bin_counts),
        .data_finish (data_finish),
        .his_num     (his_num)
    );

endmodule

// ==== hw/hist_counters.sv ====
`timescale 1ns/100ps
`include "hist_settings.svh"

module hist_counters (
    input  logic      clk,
    input  logic      res,
    hist_ctrl_if.cnt  ctrl
);

    import hist_pkg::*;

    localparam int IN_W  = $clog2(`HIST_INPUTS_PER_PIXEL + 1);
    localparam int PIX_W = $clog2(`HIST_PIXELS_PER_ACQ + 1);

    logic [IN_W-1:0]  in_cnt;
    logic [PIX_W-1:0] pix_cnt;
    logic             in_last;
    logic             pix_last;
    logic             in_sweep;
    bin_addr_t        sweep_cnt;

    // ##################################################
    // Input and pixel counters
    // ##################################################

    assign in_last  = (in_cnt == IN_W'(`HIST_INPUTS_PER_PIXEL - 1));
    assign pix_last = (pix_cnt == PIX_W'(`HIST_PIXELS_PER_ACQ - 1));

    // Pixel wrap closes the acquisition
    assign ctrl.acq_done = ctrl.hit && in_last && pix_last;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            in_cnt  <= '0;
            pix_cnt <= '0;
        end else if (ctrl.state == ST_CLEAR) begin
            in_cnt  <= '0;
            pix_cnt <= '0;
        end else if (ctrl.hit) begin
            if (in_last) begin
                in_cnt  <= '0;
                pix_cnt <= pix_last ? '0 : pix_cnt + 1'b1;
            end else begin
                in_cnt <= in_cnt + 1'b1;
            end
        end
    end

    // ##################################################
    // Bin sweep timer
    // ##################################################

    assign in_sweep = (ctrl.state == ST_CLEAR) || (ctrl.state == ST_READOUT);

    assign ctrl.sweep_addr = sweep_cnt;
    assign ctrl.sweep_last = in_sweep && (sweep_cnt == bin_addr_t'(`HIST_BINS - 1));

    // Held at zero between sweeps, so every sweep starts at bin 0
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sweep_cnt <= '0;
        end else if (!in_sweep || ctrl.sweep_last) begin
            sweep_cnt <= '0;
        end else begin
            sweep_cnt <= sweep_cnt + 1'b1;
        end
    end

endmodule

// ==== hw/hist_ctrl_if.sv ====
`timescale 1ns/100ps

interface hist_ctrl_if;

    import hist_pkg::*;

    // Sequencer outputs
    hist_state_t state;
    logic        hit;

    // Sweep timer and acquisition counter outputs
    bin_addr_t   sweep_addr;
    logic        sweep_last;
    logic        acq_done;

    // ##################################################
    // Views of the three design blocks
    // ##################################################

    modport fsm (
        output state,
        output hit,
        input  sweep_last,
        input  acq_done
    );

    modport cnt (
        input  state,
        input  hit,
        output sweep_addr,
        output sweep_last,
        output acq_done
    );

    // Bin memory only listens
    modport ram (
        input  state,
        input  hit,
        input  sweep_addr
    );

endinterface

// ==== hw/hist_fsm.sv ====
`timescale 1ns/100ps

module hist_fsm (
    input  logic      clk,
    input  logic      res,
    input  logic      wr_en,
    output logic      ready,
    hist_ctrl_if.fsm  ctrl
);

    import hist_pkg::*;

    hist_state_t state;
    hist_state_t next_state;

    // ##################################################
    // State register
    // ##################################################

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= ST_CLEAR;
        end else begin
            state <= next_state;
        end
    end

    // ##################################################
    // Next-state logic
    // ##################################################

    always_comb begin
        next_state = state;
        case (state)
            ST_CLEAR: begin
                // Whole memory zeroed once the sweep ends
                if (ctrl.sweep_last) begin
                    next_state = ST_ACCUM;
                end
            end
            ST_ACCUM: begin
                if (ctrl.acq_done) begin
                    next_state = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                // One cycle so the last increment lands
                next_state = ST_READOUT;
            end
            ST_READOUT: begin
                if (ctrl.sweep_last) begin
                    next_state = ST_CLEAR;
                end
            end
            default: begin
                next_state = ST_CLEAR;
            end
        endcase
    end

    // ##################################################
    // Outputs
    // ##################################################

    assign ready      = (state == ST_ACCUM);
    assign ctrl.state = state;

    // Strobes outside accumulation are dropped here
    assign ctrl.hit   = wr_en && (state == ST_ACCUM);

endmodule

// ==== hw/hist_pkg.sv ====
`include "hist_settings.svh"

package hist_pkg;

    // ##################################################
    // Sequencer states
    // ##################################################

    // Clear sweep, event accumulation, one drain cycle, readout sweep
    typedef enum logic [1:0] {
        ST_CLEAR   = 2'b00,
        ST_ACCUM   = 2'b01,
        ST_DRAIN   = 2'b10,
        ST_READOUT = 2'b11
    } hist_state_t;

    // ##################################################
    // Bin memory data types
    // ##################################################

    // Time-bin address
    typedef logic [`HIST_NB-1:0] bin_addr_t;

    // Hit count held in one bin
    typedef logic [`HIST_CW-1:0] bin_count_t;

endpackage

// ==== hw/hist_settings.svh ====
`ifndef HIST_SETTINGS_SVH
`define HIST_SETTINGS_SVH

// ##################################################
// Bin memory geometry
// ##################################################

// Address width of one time bin
`define HIST_NB 4
`define HIST_BINS (1 << `HIST_NB)

// Width of one bin count, saturates at all ones
`define HIST_CW 8

// ##################################################
// Acquisition structure
// ##################################################

`define HIST_INPUTS_PER_PIXEL 4
`define HIST_PIXELS_PER_ACQ 3

`endif

// ==== project.f ====
+incdir+hw
hw/hist_pkg.sv
hw/hist_ctrl_if.sv
hw/hist_fsm.sv
hw/hist_counters.sv
hw/hist_bin_ram.sv
hw/hist_builder_top.sv
tests/hist_checker.sv
tests/tb_hist_builder.sv

// ==== tests/hist_checker.sv ====
`timescale 1ns/100ps
`include "hist_settings.svh"

module hist_checker (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 wr_en,
    input  hist_pkg::bin_addr_t  addr,
    input  logic                 ready,
    input  logic                 bin_valid,
    input  logic                 data_finish,
    input  logic                 his_num,
    input  hist_pkg::bin_count_t bin_counts,
    output int                   errors,
    output int                   readouts
);

    import hist_pkg::*;

    localparam int ACQ_HITS = `HIST_INPUTS_PER_PIXEL * `HIST_PIXELS_PER_ACQ;

    bin_count_t model [`HIST_BINS];
    int         cycle;
    int         last_hit;
    int         acc_hits;
    int         bin_idx;
    int         clear_cycles;
    logic       startup;
    logic       exp_his;
    logic       prev_ready;
    logic       prev_valid;
    logic       ready_due_low;

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected 0x%0h, got 0x%0h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic flag_error(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // ##################################################
    // Sampled on the falling edge, where all ports are settled
    // ##################################################

    always @(negedge clk) begin
        if (!res) begin
            for (int b = 0; b < `HIST_BINS; b++) begin
                model[b] = '0;
            end
            {cycle, last_hit, acc_hits, bin_idx, clear_cycles} = '0;
            {errors, readouts} = '0;
            {exp_his, prev_ready, prev_valid, ready_due_low} = '0;
            startup = 1'b1;
        end else begin
            cycle++;
            // First clear sweep keeps every output quiet
            if (startup) begin
                compare_value("bin_valid", 0, bin_valid);
                compare_value("data_finish", 0, data_finish);
                if (!ready) begin
                    clear_cycles++;
                end else begin
                    if (clear_cycles != `HIST_BINS) begin
                        flag_error($sformatf("ready rose after %0d clear cycles instead of %0d",
                                             clear_cycles, `HIST_BINS));
                    end
                    startup = 1'b0;
                end
            end
            if (ready_due_low) begin
                compare_value("ready", 0, ready);
                ready_due_low = 1'b0;
            end else if (prev_ready && !ready) begin
                flag_error("ready fell before the acquisition was complete");
            end
            if (wr_en && ready) begin
                if (model[addr] != '1) begin
                    model[addr] = model[addr] + 1'b1;
                end
                last_hit = cycle;
                acc_hits++;
                if (acc_hits == ACQ_HITS) begin
                    acc_hits = 0;
                    ready_due_low = 1'b1;
                end
            end
            if (bin_valid) begin
                if (bin_idx == 0 && cycle - last_hit != 4) begin
                    flag_error($sformatf("first bin came %0d cycles after the last hit",
                                         cycle - last_hit));
                end
                if (bin_idx >= `HIST_BINS) begin
                    flag_error("more bins were read out than the memory holds");
                end else begin
                    compare_value($sformatf("bin_counts[%0d]", bin_idx), model[bin_idx],
                                  bin_counts);
                end
                bin_idx++;
            end
            if (data_finish) begin
                if (bin_idx != `HIST_BINS || !prev_valid) begin
                    flag_error("data_finish did not follow the last bin");
                end
                for (int b = 0; b < `HIST_BINS; b++) begin
                    model[b] = '0;
                end
                bin_idx = 0;
                exp_his = ~exp_his;
                readouts++;
            end
            compare_value("his_num", exp_his, his_num);
            prev_ready = ready;
            prev_valid = bin_valid;
        end
    end

endmodule

// ==== tests/tb_hist_builder.sv ====
`timescale 1ns/100ps
`include "hist_settings.svh"

module tb_hist_builder;

    import hist_pkg::*;

    localparam int ACQ_HITS   = `HIST_INPUTS_PER_PIXEL * `HIST_PIXELS_PER_ACQ;
    localparam int WAIT_LIMIT = 8 * `HIST_BINS + 64;
    localparam int ACQS       = 3;

    // One row per cycle
    // The low flag marks a row given while ready should be low
    typedef struct packed {
        logic      wr;
        bin_addr_t addr;
        logic      low;
    } row_t;

    logic        clk;
    logic        res;
    logic        wr_en;
    bin_addr_t   addr;
    logic        ready;
    logic        bin_valid;
    logic        data_finish;
    logic        his_num;
    bin_count_t  bin_counts;

    row_t        rows [$];
    int          mix_bins [12] = '{3, 3, 7, 0, 15, 7, 7, 10, 3, 1, 15, 5};
    int          row_idx;
    int          tb_errors;
    int          chk_errors;
    int          readouts;
    logic        timed_out;

    always #5 clk = ~clk;

    hist_builder_top i_dut (
        .clk         (clk),
        .res         (res),
        .wr_en       (wr_en),
        .addr        (addr),
        .ready       (ready),
        .bin_valid   (bin_valid),
        .data_finish (data_finish),
        .his_num     (his_num),
        .bin_counts  (bin_counts)
    );

    hist_checker i_checker (
        .clk         (clk),
        .res         (res),
        .wr_en       (wr_en),
        .addr        (addr),
        .ready       (ready),
        .bin_valid   (bin_valid),
        .data_finish (data_finish),
        .his_num     (his_num),
        .bin_counts  (bin_counts),
        .errors      (chk_errors),
        .readouts    (readouts)
    );

    task automatic add_row(input logic wr, input bin_addr_t a, input logic low);
        row_t r;
        r.wr   = wr;
        r.addr = a;
        r.low  = low;
        rows.push_back(r);
    endtask

    // ##################################################
    // Stimulus table
    // ##################################################

    task automatic build_table();
        // Mixed bins, back-to-back repeats and a few idle cycles
        for (int i = 0; i < ACQ_HITS; i++) begin
            add_row(1'b1, bin_addr_t'(mix_bins[i % 12]), 1'b0);
            if (i % 5 == 2) begin
                add_row(1'b0, '0, 1'b0);
            end
        end
        add_row(1'b1, bin_addr_t'(4), 1'b1);
        add_row(1'b1, bin_addr_t'(3), 1'b1);
        // Random bins would show leftovers from the first histogram
        for (int i = 0; i < ACQ_HITS; i++) begin
            add_row(1'b1, bin_addr_t'($urandom % `HIST_BINS), 1'b0);
        end
        add_row(1'b1, bin_addr_t'(12), 1'b1);
        add_row(1'b0, '0, 1'b1);
        // One bin only
        // Saturates once HIST_INPUTS_PER_PIXEL is raised to 100
        for (int i = 0; i < ACQ_HITS; i++) begin
            add_row(1'b1, bin_addr_t'(9), 1'b0);
        end
        add_row(1'b1, bin_addr_t'(9), 1'b1);
        add_row(1'b1, bin_addr_t'(9), 1'b1);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready && n < WAIT_LIMIT) begin
            wr_en = 1'b0;
            @(posedge clk);
            #1;
            n++;
        end
        if (!ready) begin
            $display("Timeout: ready stayed low for %0d cycles before row %0d", n, row_idx);
            tb_errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_finish();
        int n;
        n = 0;
        while (!data_finish && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!data_finish) begin
            $display("Timeout: no data_finish within %0d cycles of the last row", n);
            tb_errors++;
            timed_out = 1'b1;
        end
    endtask

    // ##################################################
    // Main sequence
    // ##################################################

    initial begin
        clk       = 1'b0;
        res       = 1'b0;
        wr_en     = 1'b0;
        addr      = '0;
        tb_errors = 0;
        timed_out = 1'b0;
        void'($urandom(32'hb7ce));
        build_table();
        repeat (4) @(posedge clk);
        #1;
        res = 1'b1;
        for (row_idx = 0; row_idx < rows.size() && !timed_out; row_idx++) begin
            if (!rows[row_idx].low) begin
                wait_ready();
            end
            wr_en = rows[row_idx].wr;
            addr  = rows[row_idx].addr;
            @(posedge clk);
            #1;
        end
        wr_en = 1'b0;
        if (!timed_out) begin
            wait_finish();
            repeat (4) @(posedge clk);
        end
        if (readouts != ACQS) begin
            $display("Expected %0d histogram readouts but saw %0d", ACQS, readouts);
            tb_errors++;
        end
        $display("Error count: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
